// ==== project.f ====
src/light_pkg.sv
src/band_hold.sv
src/light_regs.sv
src/light_effects.sv
src/light_top.sv
test/light_sva.sv
test/light_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the light bar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module light_tb -f project.f

status=0
sim_out=$(./obj_dir/Vlight_tb 2>&1) || status=$?
echo "$sim_out"
if [ "$status" -eq 0 ] && grep -qF '*** PASSED ***' <<< "$sim_out"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

// ==== test/light_tb.sv ====
// testbench for light_top
// inputs driven 2 ns after the rising edge
// n of 8 or more on the VU meter cannot occur with four 8-bit bands
`timescale 1ns/10ps
`default_nettype none

module light_tb;
    import light_pkg::*;

    localparam int clk_period      = 40;
    localparam int reset_cycles    = 16;
    localparam int num_rand_frames = 12;
    localparam int total_frames    = num_rand_frames + 9;
    localparam int frame_cycles    = num_bands + 2;
    localparam int bus_ops         = total_frames * (num_bands + 1) + 40;
    localparam int chase_cycles    = 32;
    localparam int watchdog_cycles =
        2 * (reset_cycles + total_frames * frame_cycles + bus_ops * 2 + chase_cycles);

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [3:0]           wb_adr;
    logic [7:0]           wb_dat_i;
    logic [7:0]           wb_dat_o;
    logic                 wb_ack;
    logic                 band_valid;
    logic [2:0]           band_index;
    logic [level_w-1:0]   band_level;
    logic [num_bands-1:0] led_pattern;

    logic [level_w-1:0]   model_held [num_bands];
    logic [level_w-1:0]   frame_lv [num_bands];
    logic [level_w-1:0]   model_decay;
    logic [mode_w-1:0]    cur_mode;
    logic [15:0]          lfsr;
    int                   frames_sent;
    int                   value_errors;
    int                   bus_errors;

    light_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .band_valid (band_valid),
        .band_index (band_index),
        .band_level (band_level),
        .led_pattern(led_pattern)
    );

    always #(clk_period / 2) clk = ~clk;

    // --------------------
    // reference model
    // --------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // peak hold keeps the larger of sample and old level minus step
    function automatic logic [7:0] hold_rule(input logic [7:0] old_lvl,
                                             input logic [7:0] sample,
                                             input logic [7:0] step);
        int lvl;
        lvl = int'(old_lvl) - int'(step);
        if (lvl < int'(sample)) begin
            lvl = int'(sample);
        end
        return 8'(lvl);
    endfunction

    function automatic logic [2:0] model_effect();
        if (!cur_mode[3]) return cur_mode[2:0];
        if (model_held[0] > pulse_thr && model_held[1] > pulse_thr) return effect_pulse;
        if (model_held[6] > star_thr && model_held[7] > star_thr) return effect_star;
        if (model_held[3] > wave_thr && model_held[4] > wave_thr) return effect_wave;
        return effect_spectrum;
    endfunction

    // low n LEDs on where n is the bass sum over 128
    function automatic logic [7:0] vu_expect();
        int sum;
        int n;
        sum = int'(model_held[0]) + int'(model_held[1]) + int'(model_held[2])
            + int'(model_held[3]);
        n = sum / 128;
        if (n >= num_bands) return 8'h00;
        return 8'(~((1 << n) - 1));
    endfunction

    task automatic draw_level(output logic [7:0] value);
        for (int b = 0; b < level_w; b++) begin
            lfsr = lfsr_step(lfsr);
            value[b] = lfsr[0];
        end
    endtask

    // --------------------
    // bus access
    // --------------------
    task automatic bus_cycle(input logic we, input logic [3:0] adr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_i = wdata;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wb_ack && waited < 8);
        rdata = wb_dat_o;
        assert (wb_ack && waited == 1) else begin
            bus_errors++;
            $display("bus access to address %0d not acknowledged on the next cycle", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(posedge clk);
        #2;
        assert (!wb_ack) else begin
            bus_errors++;
            $display("ack at address %0d lasted more than one cycle", adr);
        end
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [7:0] data);
        logic [7:0] rdata;
        bus_cycle(1'b1, adr, data, rdata);
        assert (rdata === 8'h00) else begin
            value_errors++;
            $display("error wb_dat_o expected %h got %h", 8'h00, rdata);
        end
    endtask

    task automatic expect_reg(input logic [3:0] adr, input logic [7:0] exp, input string name);
        logic [7:0] got;
        bus_cycle(1'b0, adr, 8'h00, got);
        assert (got === exp) else begin
            value_errors++;
            $display("error %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic expect_led(input logic [7:0] exp);
        assert (led_pattern === exp) else begin
            value_errors++;
            $display("error led_pattern expected %h got %h", exp, led_pattern);
        end
    endtask

    task automatic set_mode(input logic [3:0] m);
        write_reg(reg_mode, {4'h0, m});
        cur_mode = m;
    endtask

    task automatic set_decay(input logic [7:0] d);
        write_reg(reg_decay, d);
        model_decay = d;
    endtask

    // --------------------
    // frames
    // --------------------
    task automatic send_frame();
        for (int i = 0; i < num_bands; i++) begin
            band_valid = 1'b1;
            band_index = 3'(i);
            band_level = frame_lv[i];
            @(posedge clk);
            #2;
        end
        band_valid = 1'b0;
        for (int i = 0; i < num_bands; i++) begin
            model_held[i] = hold_rule(model_held[i], frame_lv[i], model_decay);
        end
        frames_sent++;
    endtask

    task automatic check_frame();
        logic [7:0] exp_led;
        repeat (2) @(posedge clk);
        #2;
        if (cur_mode == {1'b0, effect_spectrum}) begin
            for (int i = 0; i < num_bands; i++) begin
                exp_led[i] = !(model_held[i] > spectrum_on);
            end
            expect_led(exp_led);
        end else if (cur_mode == {1'b0, effect_vu_meter}) begin
            expect_led(vu_expect());
        end
        for (int i = 0; i < num_bands; i++) begin
            expect_reg(4'(reg_level_base + i), model_held[i], $sformatf("level[%0d]", i));
        end
        expect_reg(reg_status, {5'(frames_sent), model_effect()}, "status");
    endtask

    // band i in byte i of lv
    task automatic fixed_frame(input logic [63:0] lv);
        for (int i = 0; i < num_bands; i++) begin
            frame_lv[i] = lv[i*8 +: 8];
        end
        send_frame();
        check_frame();
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog timeout after %0d cycles, the run did not finish", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 4'h0;
        wb_dat_i = 8'h00;
        band_valid = 1'b0;
        band_index = 3'd0;
        band_level = 8'h00;
        lfsr = 16'd62397;
        frames_sent = 0;
        value_errors = 0;
        bus_errors = 0;
        cur_mode = mode_reset;
        model_decay = decay_reset;
        for (int i = 0; i < num_bands; i++) begin
            model_held[i] = 8'h00;
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;

        expect_led(8'hFF);
        expect_reg(reg_mode, {4'h0, mode_reset}, "mode");
        expect_reg(reg_decay, decay_reset, "decay");
        expect_reg(reg_status, 8'h00, "status");
        for (int i = 0; i < num_bands; i++) begin
            expect_reg(4'(reg_level_base + i), 8'h00, $sformatf("level[%0d]", i));
        end

        // register read-back, status and unmapped words
        set_decay(8'h0A);
        expect_reg(reg_decay, 8'h0A, "decay");
        write_reg(reg_mode, 8'hF7);
        cur_mode = 4'h7;
        expect_reg(reg_mode, 8'h07, "mode");
        set_mode({1'b0, effect_spectrum});
        write_reg(reg_status, 8'hFF);
        expect_reg(reg_status, 8'h00, "status");
        for (int a = 3; a < 8; a++) begin
            write_reg(4'(a), 8'h5A);
            expect_reg(4'(a), 8'h00, $sformatf("unmapped[%0d]", a));
        end

        for (int f = 0; f < num_rand_frames; f++) begin
            for (int i = 0; i < num_bands; i++) begin
                draw_level(frame_lv[i]);
            end
            send_frame();
            check_frame();
        end

        // full decay makes each held level equal the last sample
        set_decay(8'hFF);
        set_mode({1'b0, effect_vu_meter});
        fixed_frame(64'h0000_0000_1414_1414);
        fixed_frame(64'h0000_0000_6464_6464);
        fixed_frame(64'h0000_0000_F0F0_F0F0);
        fixed_frame(64'hFFFF_FFFF_FFFF_FFFF);

        set_mode(4'h8);
        fixed_frame(64'h0000_0000_0000_D2D2);
        fixed_frame(64'hFFFF_FFFF_FFFF_FFFF);
        fixed_frame(64'hBEBE_00A0_A000_9696);
        fixed_frame(64'h64BE_00A0_A000_0000);
        fixed_frame(64'h0000_0000_0000_FAC8);

        set_mode({1'b0, effect_chase});
        repeat (chase_cycles) begin
            assert ($countones(~led_pattern) == 1) else begin
                value_errors++;
                $display("error led_pattern expected one low bit got %h", led_pattern);
            end
            @(posedge clk);
            #2;
        end

        $display("errors: %0d value, %0d bus", value_errors, bus_errors);
        if (value_errors == 0 && bus_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/light_sva.sv ====
// concurrent bus, frame and reset checks, bound into light_top
// frame_done is observed inside the top level through the bind
`timescale 1ns/10ps
`default_nettype none

module light_sva (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             wb_cyc,
    input logic                             wb_stb,
    input logic                             wb_ack,
    input logic                             band_valid,
    input logic [2:0]                       band_index,
    input logic                             frame_done,
    input logic [light_pkg::num_bands-1:0]  led_pattern
);
    import light_pkg::*;

    // ack only answers a request from the previous cycle
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
        else $error("wb_ack raised without a request on the previous cycle");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held high for two cycles");

    // frame closes on the last band index
    frame_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> $past(band_valid && band_index == 3'(num_bands - 1)))
        else $error("frame_done without a last-band sample");

    reset_outputs: assert property (@(posedge clk)
        $rose(rst_n) |-> (led_pattern == '1 && !wb_ack && !frame_done))
        else $error("outputs not at reset values when reset ends");

endmodule

bind light_top light_sva u_light_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .band_valid  (band_valid),
    .band_index  (band_index),
    .frame_done  (frame_done),
    .led_pattern (led_pattern)
);

`default_nettype wire

// ==== src/light_top.sv ====
// light bar subsystem top, Wishbone classic slave plus band input
// led_pattern is active low, all ones after reset
// single clock domain, no brightness PWM
`timescale 1ns/10ps
`default_nettype none

module light_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [3:0]                       wb_adr,
    input  logic [7:0]                       wb_dat_i,
    output logic [7:0]                       wb_dat_o,
    output logic                             wb_ack,
    input  logic                             band_valid,
    input  logic [2:0]                       band_index,
    input  logic [light_pkg::level_w-1:0]    band_level,
    output logic [light_pkg::num_bands-1:0]  led_pattern
);
    import light_pkg::*;

    logic [flat_w-1:0]  held_flat;
    logic               frame_done;
    logic [mode_w-1:0]  mode;
    logic [level_w-1:0] decay;
    logic [2:0]         active_effect;

    band_hold u_band_hold (
        .clk        (clk),
        .rst_n      (rst_n),
        .band_valid (band_valid),
        .band_index (band_index),
        .band_level (band_level),
        .decay      (decay),
        .held_flat  (held_flat),
        .frame_done (frame_done)
    );

    light_regs u_light_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack        (wb_ack),
        .held_flat     (held_flat),
        .frame_done    (frame_done),
        .active_effect (active_effect),
        .mode          (mode),
        .decay         (decay)
    );

    light_effects u_light_effects (
        .clk           (clk),
        .rst_n         (rst_n),
        .held_flat     (held_flat),
        .mode          (mode),
        .active_effect (active_effect),
        .led_pattern   (led_pattern)
    );

endmodule

`default_nettype wire

// ==== src/light_effects.sv ====
// turns held band levels and the mode into an active-low LED pattern
// auto mode picks pulse, star, wave or spectrum from band thresholds
// pattern is registered, auto choice adds one more cycle of latency
`timescale 1ns/10ps
`default_nettype none

module light_effects (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [light_pkg::flat_w-1:0]     held_flat,
    input  logic [light_pkg::mode_w-1:0]     mode,
    output logic [2:0]                       active_effect,
    output logic [light_pkg::num_bands-1:0]  led_pattern
);
    import light_pkg::*;

    logic [level_w-1:0]   lvl [num_bands];
    logic [level_w-1:0]   brightness [num_bands];
    logic [23:0]          effect_counter;
    logic [2:0]           auto_effect;
    logic [num_bands-1:0] chase_position;
    logic [level_w-1:0]   fade_level;
    logic [15:0]          random_seed;
    logic [10:0]          vu_sum;
    logic                 chase_step;
    logic                 random_step;

    always_comb begin
        for (int i = 0; i < num_bands; i++) begin
            lvl[i] = held_flat[i*level_w +: level_w];
        end
    end

    assign active_effect = mode[mode_w-1] ? auto_effect : mode[2:0];

    // bass energy over bands 0..3
    assign vu_sum = 11'(lvl[0]) + 11'(lvl[1]) + 11'(lvl[2]) + 11'(lvl[3]);

    assign chase_step  = (effect_counter[chase_step_bits-1:0] == '0);
    assign random_step = (effect_counter[random_step_bits-1:0] == '0);

    // --------------------
    // auto selector
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            auto_effect <= effect_spectrum;
        end else if (lvl[0] > pulse_thr && lvl[1] > pulse_thr) begin
            auto_effect <= effect_pulse;
        end else if (lvl[6] > star_thr && lvl[7] > star_thr) begin
            auto_effect <= effect_star;
        end else if (lvl[3] > wave_thr && lvl[4] > wave_thr) begin
            auto_effect <= effect_wave;
        end else begin
            auto_effect <= effect_spectrum;
        end
    end

    // free-running effect counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            effect_counter <= '0;
        end else begin
            effect_counter <= effect_counter + 24'd1;
        end
    end

    // wave phases, one eighth of a turn apart per LED
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_bands; i++) begin
            brightness[i] <= effect_counter[18:11] + {3'(i), 5'd0};
        end
    end

    // --------------------
    // effect generator
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_pattern    <= '1;
            chase_position <= 8'b0000_0001;
            fade_level     <= '0;
            random_seed    <= 16'hA5A5;
        end else begin
            case (active_effect)
                effect_spectrum: begin
                    for (int i = 0; i < num_bands; i++) begin
                        led_pattern[i] <= !(lvl[i] > spectrum_on);
                    end
                end
                effect_pulse: begin
                    // triangle ramp against half the bass level
                    if (!effect_counter[19]) begin
                        fade_level <= effect_counter[19:12];
                    end else begin
                        fade_level <= 8'd255 - effect_counter[19:12];
                    end
                    led_pattern <= {num_bands{fade_level > (lvl[0] >> 1)}};
                end
                effect_wave: begin
                    for (int i = 0; i < num_bands; i++) begin
                        led_pattern[i] <= !(brightness[i] > 8'd128);
                    end
                end
                effect_star: begin
                    random_seed <= {random_seed[14:0], random_seed[15] ^ random_seed[13]};
                    for (int i = 0; i < num_bands; i++) begin
                        led_pattern[i] <= !(random_seed[i] && lvl[i] > star_min);
                    end
                end
                effect_chase: begin
                    if (chase_step) begin
                        chase_position <= {chase_position[num_bands-2:0],
                                           chase_position[num_bands-1]};
                    end
                    led_pattern <= ~chase_position;
                end
                effect_fade: begin
                    fade_level <= effect_counter[19:12];
                    for (int i = 0; i < num_bands; i++) begin
                        led_pattern[i] <= !(fade_level > {3'(i), 5'd0});
                    end
                end
                effect_random: begin
                    if (random_step) begin
                        random_seed <= {random_seed[14:0],
                                        random_seed[15] ^ random_seed[13]};
                        led_pattern <= random_seed[num_bands-1:0];
                    end
                end
                default: begin
                    // vu meter, low n LEDs lit
                    if (vu_sum[10]) begin
                        led_pattern <= '0;
                    end else begin
                        led_pattern <= 8'hFF << vu_sum[9:7];
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/light_regs.sv ====
// Wishbone classic slave, one-cycle ack, no wait states, no err
// master must drop stb after ack
// unmapped addresses read zero and ignore writes
`timescale 1ns/10ps
`default_nettype none

module light_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [3:0]                       wb_adr,
    input  logic [7:0]                       wb_dat_i,
    output logic [7:0]                       wb_dat_o,
    output logic                             wb_ack,
    input  logic [light_pkg::flat_w-1:0]     held_flat,
    input  logic                             frame_done,
    input  logic [2:0]                       active_effect,
    output logic [light_pkg::mode_w-1:0]     mode,
    output logic [light_pkg::level_w-1:0]    decay
);
    import light_pkg::*;

    logic       req;
    logic [4:0] frame_cnt;
    logic [7:0] rd_data;

    // a request is served once, the ack cycle is not a new request
    assign req = wb_cyc && wb_stb && !wb_ack;

    // --------------------
    // read mux
    // --------------------
    always_comb begin
        rd_data = '0;
        if (wb_adr >= reg_level_base) begin
            rd_data = held_flat[wb_adr[2:0]*level_w +: level_w];
        end else begin
            case (wb_adr)
                reg_mode:   rd_data = {{(8 - mode_w){1'b0}}, mode};
                reg_decay:  rd_data = decay;
                reg_status: rd_data = {frame_cnt, active_effect};
                default:    rd_data = '0;
            endcase
        end
    end

    // --------------------
    // bus handshake and registers
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
            mode     <= mode_reset;
            decay    <= decay_reset;
        end else begin
            wb_ack <= req;
            if (req) begin
                wb_dat_o <= wb_we ? 8'h00 : rd_data;
            end
            if (req && wb_we) begin
                case (wb_adr)
                    reg_mode:  mode  <= wb_dat_i[mode_w-1:0];
                    reg_decay: decay <= wb_dat_i;
                    default:   ;
                endcase
            end
        end
    end

    // frame count for status, wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (frame_done) begin
            frame_cnt <= frame_cnt + 5'd1;
        end
    end

endmodule

`default_nettype wire

// ==== src/band_hold.sv ====
// collects eight band samples per frame, index 7 closes the frame
// no back-pressure, the source must pace its samples
// frame buffer holds bands 0..6 only and is not reset
`timescale 1ns/10ps
`default_nettype none

module band_hold (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             band_valid,
    input  logic [2:0]                       band_index,
    input  logic [light_pkg::level_w-1:0]    band_level,
    input  logic [light_pkg::level_w-1:0]    decay,
    output logic [light_pkg::flat_w-1:0]     held_flat,
    output logic                             frame_done
);
    import light_pkg::*;

    logic [level_w-1:0] frame_buf [num_bands-1];
    logic [flat_w-1:0]  next_held;
    logic               frame_end;

    // max of new sample and old level minus step, floored at zero
    function automatic logic [level_w-1:0] peak_hold(
        input logic [level_w-1:0] old_lvl,
        input logic [level_w-1:0] sample,
        input logic [level_w-1:0] step
    );
        logic [level_w-1:0] decayed;
        decayed = (old_lvl > step) ? old_lvl - step : '0;
        return (sample > decayed) ? sample : decayed;
    endfunction

    assign frame_end = band_valid && (band_index == 3'(num_bands - 1));

    // --------------------
    // frame buffer
    // --------------------
    always_ff @(posedge clk) begin
        if (band_valid && !frame_end) begin
            frame_buf[band_index] <= band_level;
        end
    end

    // last band comes straight from the input
    always_comb begin
        for (int i = 0; i < num_bands - 1; i++) begin
            next_held[i*level_w +: level_w] =
                peak_hold(held_flat[i*level_w +: level_w], frame_buf[i], decay);
        end
        next_held[flat_w-1 -: level_w] =
            peak_hold(held_flat[flat_w-1 -: level_w], band_level, decay);
    end

    // --------------------
    // held levels
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_flat  <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= frame_end;
            if (frame_end) begin
                held_flat <= next_held;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/light_pkg.sv ====
// shared constants for the LED light bar subsystem
// band count and widths are fixed by the eight-LED bar
`default_nettype none

package light_pkg;

    localparam int num_bands = 8;
    localparam int level_w   = 8;
    localparam int mode_w    = 4;
    localparam int flat_w    = num_bands * level_w;

    // effect codes
    localparam logic [2:0] effect_spectrum = 3'd0;
    localparam logic [2:0] effect_pulse    = 3'd1;
    localparam logic [2:0] effect_wave     = 3'd2;
    localparam logic [2:0] effect_star     = 3'd3;
    localparam logic [2:0] effect_chase    = 3'd4;
    localparam logic [2:0] effect_fade     = 3'd5;
    localparam logic [2:0] effect_random   = 3'd6;
    localparam logic [2:0] effect_vu_meter = 3'd7;

    // level thresholds, all compared with >
    localparam logic [level_w-1:0] spectrum_on = 8'd128;
    localparam logic [level_w-1:0] pulse_thr   = 8'd200;
    localparam logic [level_w-1:0] star_thr    = 8'd180;
    localparam logic [level_w-1:0] wave_thr    = 8'd150;
    localparam logic [level_w-1:0] star_min    = 8'd100;

    localparam int chase_step_bits  = 18;
    localparam int random_step_bits = 16;

    // register word addresses
    localparam logic [3:0] reg_mode       = 4'd0;
    localparam logic [3:0] reg_decay      = 4'd1;
    localparam logic [3:0] reg_status     = 4'd2;
    localparam logic [3:0] reg_level_base = 4'd8;

    localparam logic [mode_w-1:0]  mode_reset  = {1'b0, effect_spectrum};
    localparam logic [level_w-1:0] decay_reset = 8'd4;

endpackage

`default_nettype wire
